// ==== idt_pkg.sv ====
package idt_pkg;

    localparam logic [7:0] VEC_PROTECTION = 8'd13;
    localparam logic [7:0] VEC_PAGE_FAULT = 8'd14;
    localparam logic [7:0] VEC_INTERRUPT  = 8'd15;

    localparam logic [7:0]  OP_PUSH_IMM      = 8'h68;
    localparam logic [7:0]  OP_MOV_EAX_MOFFS = 8'ha1;
    localparam logic [15:0] OP_XCHG          = 16'h6693;   // XCHG AX, BX
    localparam logic [23:0] OP_SAR           = 24'hc1f804; // SAR EAX, 4
    localparam logic [23:0] OP_MOV_CS        = 24'h668ec8;
    localparam logic [15:0] OP_JMP           = 16'hffe3;   // JMP EBX
    localparam logic [7:0]  OP_RET_FAR       = 8'hcb;
    localparam logic [7:0]  OP_POP           = 8'h58;

    localparam logic [31:0] AXIL_REG_BASE   = 32'h0;
    localparam logic [31:0] AXIL_REG_STATUS = 32'h4;

    typedef struct packed {
        logic        valid;
        logic [2:0]  ie_type;  // Bit 0 protection, 1 page fault, 2 interrupt
        logic [31:0] eip;
        logic [17:0] eflags;
        logic [15:0] cs;
    } ie_event_t;

    typedef struct packed {
        logic [31:0] gate_addr;
        logic [31:0] gate_addr4;
        logic [17:0] eflags;
        logic [15:0] cs;
        logic [31:0] eip;
    } ie_frame_t;

    typedef struct packed {
        logic         injected;
        logic [127:0] data;
    } fetch_pkt_t;

    // Sequencer steps by increment through this order
    typedef enum logic [3:0] {
        STEP_IDLE, STEP_FLUSH, STEP_PUSH_EFLAGS, STEP_PUSH_CS, STEP_PUSH_EIP,
        STEP_LOAD_LO, STEP_LOAD_HI, STEP_EXCHANGE, STEP_SHIFT, STEP_MOV_CS,
        STEP_JUMP, STEP_WAIT_IRET, STEP_RET_FAR, STEP_POP_EFLAGS
    } pkt_step_t;

endpackage

// ==== idt_cfg_axil.sv ====
module idt_cfg_axil #(
    parameter logic [31:0] IDT_BASE_RESET = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic [1:0]  rresp,
    input  logic        rready,
    input  logic        taken,
    input  logic        servicing,
    output logic [31:0] idt_base
);

    logic        aw_held, w_held;
    logic [31:0] aw_addr_q, w_data_q;
    logic [3:0]  w_strb_q;
    logic [7:0]  taken_count;
    logic        aw_fire, w_fire, wr_go;
    logic [31:0] wr_addr, wr_data;
    logic [3:0]  wr_strb;

    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign wr_go   = (aw_held || aw_fire) && (w_held || w_fire);

    // Use the held copy when the beat came earlier
    assign wr_addr = aw_held ? aw_addr_q : awaddr;
    assign wr_data = w_held ? w_data_q : wdata;
    assign wr_strb = w_held ? w_strb_q : wstrb;

    always_ff @(posedge clk) begin
        if (aw_fire) aw_addr_q <= awaddr;
        if (w_fire) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            bvalid   <= 1'b0;
            idt_base <= IDT_BASE_RESET;
        end else begin
            if (wr_go) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_addr == idt_pkg::AXIL_REG_BASE) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) idt_base[8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
            end else begin
                if (aw_fire) aw_held <= 1'b1;
                if (w_fire) w_held <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end
        end
    end

    assign arready = !rvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            case (araddr)
                idt_pkg::AXIL_REG_BASE:   rdata <= idt_base;
                idt_pkg::AXIL_REG_STATUS: rdata <= {16'h0, taken_count, 7'h0, servicing};
                default:                  rdata <= 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) taken_count <= 8'h0;
        else if (taken) taken_count <= taken_count + 8'h1;  // Wraps
    end

    assign bresp = 2'b00;
    assign rresp = 2'b00;

endmodule

// ==== ie_capture.sv ====
module ie_capture (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  idt_pkg::ie_event_t  wb_event,
    input  logic [31:0]         idt_base,
    input  logic                busy,
    output logic                start,
    output idt_pkg::ie_frame_t  frame,
    output logic                taken
);

    logic        accept;
    logic [7:0]  vector;
    logic [31:0] gate_addr;

    assign accept = wb_event.valid && enable && !busy;

    // Lowest set type bit wins
    always_comb begin
        if (wb_event.ie_type[0]) vector = idt_pkg::VEC_PROTECTION;
        else if (wb_event.ie_type[1]) vector = idt_pkg::VEC_PAGE_FAULT;
        else vector = idt_pkg::VEC_INTERRUPT;
    end

    assign gate_addr = idt_base + {21'h0, vector, 3'b000};  // Eight byte gates

    always_ff @(posedge clk) begin
        if (accept) begin
            frame.gate_addr  <= gate_addr;
            frame.gate_addr4 <= gate_addr + 32'd4;
            frame.eflags     <= wb_event.eflags;
            frame.cs         <= wb_event.cs;
            frame.eip        <= wb_event.eip;
        end
    end

    // Count pulse only while out of reset
    assign start = accept;
    assign taken = accept && !reset;

endmodule

// ==== ie_sequencer.sv ====
module ie_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               start,
    input  logic               iretd,
    input  logic               inject_ready,
    output idt_pkg::pkt_step_t step,
    output logic               inject_valid,
    output logic               flush_pipe,
    output logic               ptc_clear,
    output logic               ld_eip,
    output logic               is_pop_eflags,
    output logic               servicing
);

    idt_pkg::pkt_step_t step_next;
    logic               pkt_step;

    // Steps that offer a packet to fetch_select
    assign pkt_step = (step != idt_pkg::STEP_IDLE) &&
                      (step != idt_pkg::STEP_FLUSH) &&
                      (step != idt_pkg::STEP_WAIT_IRET);

    always_comb begin
        step_next = step;
        case (step)
            idt_pkg::STEP_IDLE: begin
                if (start) step_next = idt_pkg::STEP_FLUSH;
            end
            idt_pkg::STEP_FLUSH: begin
                step_next = idt_pkg::STEP_PUSH_EFLAGS;
            end
            idt_pkg::STEP_WAIT_IRET: begin
                if (iretd) step_next = idt_pkg::STEP_RET_FAR;
            end
            idt_pkg::STEP_POP_EFLAGS: begin
                if (inject_ready) step_next = idt_pkg::STEP_IDLE;
            end
            default: begin
                // Packet steps move on only when the packet is taken
                if (inject_ready) step_next = idt_pkg::pkt_step_t'(step + 4'd1);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= idt_pkg::STEP_IDLE;
        end else if (enable) begin
            step <= step_next;
        end
    end

    assign inject_valid  = pkt_step && enable;  // No take while frozen
    assign flush_pipe    = (step == idt_pkg::STEP_FLUSH);
    assign ptc_clear     = flush_pipe;
    assign ld_eip        = (step == idt_pkg::STEP_JUMP) || (step == idt_pkg::STEP_RET_FAR);
    assign is_pop_eflags = (step == idt_pkg::STEP_POP_EFLAGS);
    assign servicing     = (step != idt_pkg::STEP_IDLE);

endmodule

// ==== packet_builder.sv ====
module packet_builder (
    input  idt_pkg::pkt_step_t step,
    input  idt_pkg::ie_frame_t frame,
    output idt_pkg::fetch_pkt_t pkt
);

    // Immediates go out little endian
    function automatic logic [31:0] swap32(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    function automatic logic [127:0] op_imm(input logic [7:0] opcode, input logic [31:0] imm);
        return {opcode, swap32(imm), 88'h0};
    endfunction

    logic [127:0] data;

    always_comb begin
        case (step)
            idt_pkg::STEP_PUSH_EFLAGS:
                data = op_imm(idt_pkg::OP_PUSH_IMM, {14'h0, frame.eflags});
            idt_pkg::STEP_PUSH_CS:
                data = op_imm(idt_pkg::OP_PUSH_IMM, {16'h0, frame.cs});
            idt_pkg::STEP_PUSH_EIP:
                data = op_imm(idt_pkg::OP_PUSH_IMM, frame.eip);
            idt_pkg::STEP_LOAD_LO:
                data = op_imm(idt_pkg::OP_MOV_EAX_MOFFS, frame.gate_addr);
            idt_pkg::STEP_LOAD_HI:
                data = op_imm(idt_pkg::OP_MOV_EAX_MOFFS, frame.gate_addr4);
            idt_pkg::STEP_EXCHANGE:
                data = {idt_pkg::OP_XCHG, 112'h0};
            idt_pkg::STEP_SHIFT:
                data = {idt_pkg::OP_SAR, 104'h0};
            idt_pkg::STEP_MOV_CS:
                data = {idt_pkg::OP_MOV_CS, 104'h0};
            idt_pkg::STEP_JUMP:
                data = {idt_pkg::OP_JMP, 112'h0};
            idt_pkg::STEP_RET_FAR:
                data = {idt_pkg::OP_RET_FAR, 120'h0};
            idt_pkg::STEP_POP_EFLAGS:
                data = {idt_pkg::OP_POP, 120'h0};   // Loads EFLAGS on this path
            default:
                data = 128'h0;
        endcase
    end

    assign pkt.injected = 1'b1;
    assign pkt.data     = data;

endmodule

// ==== fetch_select.sv ====
module fetch_select (
    input  logic                clk,
    input  logic                reset,
    input  logic                servicing,
    input  logic                inject_valid,
    input  idt_pkg::fetch_pkt_t inject_pkt,
    output logic                inject_ready,
    input  logic                ibuf_valid,
    input  logic [127:0]        ibuf_pkt,
    output logic                ibuf_ready,
    output logic                dec_valid,
    output idt_pkg::fetch_pkt_t dec_pkt,
    input  logic                dec_ready
);

    idt_pkg::fetch_pkt_t src_pkt;
    logic                src_valid;
    logic                can_load;

    assign can_load     = !dec_valid || dec_ready;
    assign inject_ready = servicing && can_load;
    assign ibuf_ready   = !servicing && can_load;

    always_comb begin
        if (servicing) begin
            src_valid = inject_valid;
            src_pkt   = inject_pkt;
        end else begin
            src_valid        = ibuf_valid;
            src_pkt.injected = 1'b0;
            src_pkt.data     = ibuf_pkt;
        end
    end

    // One-entry output register
    always_ff @(posedge clk) begin
        if (reset) dec_valid <= 1'b0;
        else if (can_load) dec_valid <= src_valid;
    end

    always_ff @(posedge clk) begin
        if (can_load && src_valid) dec_pkt <= src_pkt;
    end

endmodule

// ==== idt_inject_top.sv ====
module idt_inject_top #(
    parameter logic [31:0] IDT_BASE_RESET = 32'h0000_1000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  idt_pkg::ie_event_t  wb_event,
    input  logic                iretd,
    input  logic                ibuf_valid,
    input  logic [127:0]        ibuf_pkt,
    output logic                ibuf_ready,
    output logic                dec_valid,
    output idt_pkg::fetch_pkt_t dec_pkt,
    input  logic                dec_ready,
    input  logic [31:0]         awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic                bvalid,
    output logic [1:0]          bresp,
    input  logic                bready,
    input  logic [31:0]         araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic                rvalid,
    output logic [1:0]          rresp,
    input  logic                rready,
    output logic                flush_pipe,
    output logic                ptc_clear,
    output logic                ld_eip,
    output logic                is_pop_eflags,
    output logic                servicing
);

    logic [31:0]         idt_base;
    logic                start, taken;
    logic                inject_valid, inject_ready;
    idt_pkg::ie_frame_t  frame;
    idt_pkg::pkt_step_t  step;
    idt_pkg::fetch_pkt_t inject_pkt;

    idt_cfg_axil #(.IDT_BASE_RESET(IDT_BASE_RESET)) u_cfg (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rresp(rresp), .rready(rready),
        .taken(taken), .servicing(servicing), .idt_base(idt_base)
    );

    ie_capture u_capture (
        .clk(clk), .reset(reset), .enable(enable),
        .wb_event(wb_event), .idt_base(idt_base), .busy(servicing),
        .start(start), .frame(frame), .taken(taken)
    );

    ie_sequencer u_seq (
        .clk(clk), .reset(reset), .enable(enable),
        .start(start), .iretd(iretd), .inject_ready(inject_ready),
        .step(step), .inject_valid(inject_valid),
        .flush_pipe(flush_pipe), .ptc_clear(ptc_clear), .ld_eip(ld_eip),
        .is_pop_eflags(is_pop_eflags), .servicing(servicing)
    );

    packet_builder u_builder (.step(step), .frame(frame), .pkt(inject_pkt));

    fetch_select u_fetch (
        .clk(clk), .reset(reset), .servicing(servicing),
        .inject_valid(inject_valid), .inject_pkt(inject_pkt), .inject_ready(inject_ready),
        .ibuf_valid(ibuf_valid), .ibuf_pkt(ibuf_pkt), .ibuf_ready(ibuf_ready),
        .dec_valid(dec_valid), .dec_pkt(dec_pkt), .dec_ready(dec_ready)
    );

endmodule

// ==== tb_idt_inject.sv ====
module tb_idt_inject;

    localparam logic [31:0] BASE_RESET = 32'h0010_0800;
    localparam int TEST_LEN_SUM = 10 + 10 + 30 + 60 + 60 + 30;  // Rough cycles per test
    localparam int TIMEOUT_CYCLES = TEST_LEN_SUM * 200;

    logic clk = 1'b0;
    logic reset, enable, iretd;
    idt_pkg::ie_event_t wb_event;
    logic ibuf_valid = 1'b0;
    logic [127:0] ibuf_pkt = 128'h0;
    logic dec_ready = 1'b1;
    logic ibuf_ready, dec_valid;
    idt_pkg::fetch_pkt_t dec_pkt;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    logic flush_pipe, ptc_clear, ld_eip, is_pop_eflags, servicing;

    logic [130:0] rx_q[$];      // {ld_eip, is_pop_eflags, injected, data}
    logic [130:0] exp_q[$];
    logic [127:0] ibuf_src[$];
    logic ld_flag = 1'b0;
    logic pop_flag = 1'b0;
    logic random_ready = 1'b0;
    logic [31:0] rnd;
    int flush_count = 0;
    logic [31:0] cur_base;

    idt_inject_top #(.IDT_BASE_RESET(BASE_RESET)) UUT (
        .clk(clk), .reset(reset), .enable(enable), .wb_event(wb_event), .iretd(iretd),
        .ibuf_valid(ibuf_valid), .ibuf_pkt(ibuf_pkt), .ibuf_ready(ibuf_ready),
        .dec_valid(dec_valid), .dec_pkt(dec_pkt), .dec_ready(dec_ready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rresp(rresp), .rready(rready),
        .flush_pipe(flush_pipe), .ptc_clear(ptc_clear), .ld_eip(ld_eip),
        .is_pop_eflags(is_pop_eflags), .servicing(servicing)
    );

    always #50 clk = ~clk;

    task automatic check(input logic [130:0] got, input logic [130:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Flags follow the packet into the output register
    always @(posedge clk) begin
        if (!reset) begin
            check(131'(ptc_clear), 131'(flush_pipe), "ptc_clear with flush_pipe");
            if (flush_pipe) flush_count++;
            if (dec_valid && dec_ready) rx_q.push_back({ld_flag, pop_flag, dec_pkt});
            if (!dec_valid || dec_ready) begin
                ld_flag  <= ld_eip;
                pop_flag <= is_pop_eflags;
            end
        end
    end

    // Instruction buffer source
    always @(posedge clk) begin
        if (!reset) begin
            if (ibuf_valid && ibuf_ready) void'(ibuf_src.pop_front());
            ibuf_valid <= (ibuf_src.size() > 0);
            ibuf_pkt   <= (ibuf_src.size() > 0) ? ibuf_src[0] : 128'h0;
        end
    end

    always @(posedge clk) begin
        rnd = $urandom;
        dec_ready <= random_ready ? rnd[0] : 1'b1;
    end

    function automatic logic [130:0] rec(input logic ld, input logic pop, input logic [127:0] data);
        return {ld, pop, 1'b1, data};
    endfunction

    // Opcode and byte-swapped immediate
    function automatic logic [127:0] imm_pkt(input logic [7:0] op, input logic [31:0] v);
        return {op, v[7:0], v[15:8], v[23:16], v[31:24], 88'h0};
    endfunction

    task automatic add_ibuf(input int n);
        logic [127:0] pkt;
        for (int i = 0; i < n; i++) begin
            pkt = {$urandom, $urandom, $urandom, $urandom};
            ibuf_src.push_back(pkt);
            exp_q.push_back({3'b000, pkt});
        end
    endtask

    task automatic compare_stream(input string what);
        logic [130:0] got;
        logic [130:0] exp;
        while (exp_q.size() > 0) begin
            while (rx_q.size() == 0) @(posedge clk);
            got = rx_q.pop_front();
            exp = exp_q.pop_front();
            check(got, exp, what);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        bit done;
        done = 1'b0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        while (!done) begin
            @(posedge clk);
            if (awvalid && awready) awvalid <= 1'b0;
            if (wvalid && wready) wvalid <= 1'b0;
            if (bvalid && bready) begin
                done = 1'b1;
                bready <= 1'b0;
                check(131'(bresp), 131'(0), "write response");
            end
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        bit done;
        done = 1'b0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        while (!done) begin
            @(posedge clk);
            if (arvalid && arready) arvalid <= 1'b0;
            if (rvalid && rready) begin
                done = 1'b1;
                data = rdata;
                rready <= 1'b0;
                check(131'(rresp), 131'(0), "read response");
            end
        end
    endtask

    // Reference entry sequence
    task automatic expect_entry(input logic [2:0] ie_type, input logic [17:0] eflags,
                                input logic [15:0] cs, input logic [31:0] eip);
        logic [31:0] vec;
        logic [31:0] gate;
        vec  = ie_type[0] ? 32'd13 : (ie_type[1] ? 32'd14 : 32'd15);
        gate = cur_base + vec * 32'd8;
        exp_q.push_back(rec(1'b0, 1'b0, imm_pkt(8'h68, {14'h0, eflags})));
        exp_q.push_back(rec(1'b0, 1'b0, imm_pkt(8'h68, {16'h0, cs})));
        exp_q.push_back(rec(1'b0, 1'b0, imm_pkt(8'h68, eip)));
        exp_q.push_back(rec(1'b0, 1'b0, imm_pkt(8'ha1, gate)));
        exp_q.push_back(rec(1'b0, 1'b0, imm_pkt(8'ha1, gate + 32'd4)));
        exp_q.push_back(rec(1'b0, 1'b0, {16'h6693, 112'h0}));
        exp_q.push_back(rec(1'b0, 1'b0, {24'hc1f804, 104'h0}));
        exp_q.push_back(rec(1'b0, 1'b0, {24'h668ec8, 104'h0}));
        exp_q.push_back(rec(1'b1, 1'b0, {16'hffe3, 112'h0}));
    endtask

    task automatic send_event(input logic [2:0] ie_type, input logic [17:0] eflags,
                              input logic [15:0] cs, input logic [31:0] eip);
        @(posedge clk);
        wb_event <= {1'b1, ie_type, eip, eflags, cs};
        @(posedge clk);
        wb_event.valid <= 1'b0;
        @(posedge clk);
        check(131'(flush_pipe), 131'(1), "flush_pipe in the cycle after the event");
    endtask

    // Second event held while busy
    task automatic offer_while_busy();
        @(posedge clk);
        wb_event <= {1'b1, 3'b001, 32'hdead_0000, 18'h3_ffff, 16'hffff};
        repeat (6) begin
            @(posedge clk);
            check(131'(servicing), 131'(1), "busy while second event offered");
        end
        wb_event.valid <= 1'b0;
    endtask

    task automatic enter(input logic [2:0] ie_type, input logic [17:0] eflags,
                         input logic [15:0] cs, input logic [31:0] eip, input bit interfere);
        int flushes;
        flushes = flush_count;
        expect_entry(ie_type, eflags, cs, eip);
        send_event(ie_type, eflags, cs, eip);
        if (interfere) offer_while_busy();
        compare_stream("entry packet");
        check(131'(flush_count - flushes), 131'(1), "flush cycles per event");
    endtask

    task automatic leave();
        exp_q.push_back(rec(1'b1, 1'b0, {8'hcb, 120'h0}));
        exp_q.push_back(rec(1'b0, 1'b1, {8'h58, 120'h0}));
        @(posedge clk);
        iretd <= 1'b1;
        @(posedge clk);
        iretd <= 1'b0;
        compare_stream("return packet");
        check(131'(servicing), 131'(0), "servicing after return");
    endtask

    task automatic config_regs_rw();
        logic [31:0] data;
        read_reg(32'h0, data);
        check(131'(data), 131'(BASE_RESET), "base after reset");
        write_reg(32'h0, 32'h5566_7788, 4'b0101);
        read_reg(32'h0, data);
        check(131'(data), 131'(32'h0066_0888), "base after strobed write");
        write_reg(32'h0, 32'h0002_0000, 4'b1111);
        write_reg(32'h4, 32'hffff_ffff, 4'b1111);  // Status is read only
        read_reg(32'h0, data);
        check(131'(data), 131'(32'h0002_0000), "base after full write");
        cur_base = 32'h0002_0000;
        read_reg(32'h4, data);
        check(131'(data), 131'(0), "status when idle");
    endtask

    task automatic idle_passthrough();
        add_ibuf(6);
        compare_stream("ibuf packet");
    endtask

    task automatic interrupt_entry();
        logic [31:0] data;
        enter(3'b100, 18'h0_0246, 16'h0008, 32'h0040_1234, 1'b0);
        read_reg(32'h4, data);
        check(131'(data), 131'(32'h0000_0101), "status while servicing");
        leave();
    endtask

    task automatic vector_priority();
        logic [31:0] data;
        enter(3'b011, 18'h2_0202, 16'h001b, 32'h0804_8000, 1'b1);
        leave();
        enter(3'b110, 18'h1_0893, 16'h0023, 32'hc000_7ff0, 1'b0);
        leave();
        read_reg(32'h4, data);
        check(131'(data), 131'(32'h0000_0300), "status after two more events");
    endtask

    task automatic random_backpressure();
        logic [31:0] r_eip;
        logic [31:0] r_ctx;
        r_eip = $urandom;
        r_ctx = $urandom;
        random_ready = 1'b1;
        add_ibuf(5);
        compare_stream("ibuf packet under back-pressure");
        enter(3'b100, r_ctx[17:0], r_ctx[31:16], r_eip, 1'b0);
        leave();
        add_ibuf(5);
        compare_stream("ibuf packet after service");
        random_ready = 1'b0;
    endtask

    task automatic iretd_return();
        enter(3'b001, 18'h0_0002, 16'h0010, 32'h0000_fff0, 1'b0);
        leave();
        add_ibuf(4);
        compare_stream("ibuf packet after return");
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    end

    initial begin
        void'($urandom(31));
        reset    = 1'b1;
        enable   = 1'b1;
        iretd    = 1'b0;
        wb_event = '0;
        awaddr   = 32'h0;
        awvalid  = 1'b0;
        wdata    = 32'h0;
        wstrb    = 4'h0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 32'h0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        cur_base = BASE_RESET;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        config_regs_rw();
        idle_passthrough();
        interrupt_entry();
        vector_priority();
        random_backpressure();
        iretd_return();
        repeat (20) @(posedge clk);
        check(131'(rx_q.size()), 131'(0), "packets beyond the expected streams");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
idt_pkg.sv
idt_cfg_axil.sv
ie_capture.sv
ie_sequencer.sv
packet_builder.sv
fetch_select.sv
idt_inject_top.sv
tb_idt_inject.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_idt_inject
FILELIST  := project.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
